/* lc3b_commit.f */
src/lc3b_commit_pkg.sv
src/rob_queue.sv
src/cc_resolve.sv
src/redirect_unit.sv
src/branch_stats.sv
src/commit_fsm.sv
src/commit_top.sv
dv/tb_clock.sv
dv/commit_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the commit stage testbench with verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module commit_tb -f lc3b_commit.f -o commit_sim \
	&& ./obj_dir/commit_sim \
	|| { echo "verilator build or simulation returned an error"; exit 1; }

/* dv/commit_tests.txt */
# E opcode dest value pc predict bht wrong_path (hex, a branch carries its nzp mask in dest)
# R dest value / P new_pc / B index tag target predict / U taken bht pc / S addr data / C totals
E 1 1 0005 3000 0 0 0
E 0 1 0010 3002 1 2 0
E 5 2 0000 3014 0 0 0
E 0 5 0020 3016 0 1 0
E 9 3 8001 3018 0 0 0
E 0 4 fff0 301a 0 3 0
E 1 4 1111 301c 0 0 1
E 7 0 4000 5555 0 0 1
E e 4 300e 300c 0 0 0
E 7 0 4000 beef 0 0 0
E 3 0 4001 00a5 0 0 0
E 7 0 4002 1234 0 0 0
E 6 5 0000 3016 0 0 0
E 0 2 0040 3018 1 0 0
E 0 1 0008 305a 1 2 0
E f 7 0200 305c 0 0 1
E d 6 7ffe 305c 0 0 0
E f 7 0400 305e 0 0 0
E 1 1 9999 3060 0 0 1
E 0 7 0002 3062 0 0 1
E 8 0 0001 0400 0 0 0
E c 0 1234 0402 0 0 0
E 0 1 0100 0404 1 3 0
R 1 0005
R 2 0000
R 3 8001
R 4 300e
R 5 0000
R 6 7ffe
R 7 0400
R 0 0001
P 300c
P 305c
P 0400
B 01 060 3014 1
B 0b 060 3018 0
B 0d 060 300c 1
B 0c 060 305a 1
B 2d 060 305c 0
B 02 008 0506 1
U 1 2 3002
U 0 1 3016
U 1 3 301a
U 1 0 3018
U 0 2 305a
U 1 3 0404
S 4000 beef
S 4001 00a5
S 4002 1234
C 0006 0002

/* dv/commit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module commit_tb;
	import lc3b_commit_pkg::*;

	logic        clk;
	logic        rst_n;
	logic        push;
	rob_entry    push_entry;
	logic        dmem_resp = 1'b0;
	rob_count    credit_return;
	reg_write    reg_wr;
	store_req    store;
	logic        flush;
	redirect_req redirect;
	btb_write    btb_wr;
	pred_update  pred_upd;
	lc3b_word    branch_total;
	lc3b_word    mispredict_total;

	rob_entry    entries[$];
	logic        wrong_path[$];
	reg_write    exp_reg[$];
	redirect_req exp_redirect[$];
	btb_write    exp_btb[$];
	pred_update  exp_pred[$];
	store_req    exp_store[$];
	lc3b_word    exp_branches;
	lc3b_word    exp_mispredicts;

	// positions in the expected streams, advanced by the monitor only.
	int          reg_seen = 0;
	int          redirect_seen = 0;
	int          btb_seen = 0;
	int          pred_seen = 0;
	int          store_seen = 0;

	int          pushed = 0;     // credits spent by the driver.
	int          returned = 0;   // credits handed back by the queue.
	int          flush_count = 0;
	int          flushes_handled;
	int          next_idx;
	logic        hold_for_flush;
	logic        running = 1'b0;
	int          cycle_count = 0;
	int          cycle_limit = 0;
	logic [31:0] seed = 32'h77b0_7883;
	logic        resp_armed = 1'b0;
	int          resp_wait = 0;
	logic        store_open = 1'b0;   // a store was waiting on memory last cycle.
	store_req    store_last = '0;

	tb_clock i_tb_clock
	(
		.clk (clk)
	);

	commit_top i_commit_top
	(
		.clk              (clk),
		.rst_n            (rst_n),
		.push             (push),
		.push_entry       (push_entry),
		.dmem_resp        (dmem_resp),
		.credit_return    (credit_return),
		.reg_wr           (reg_wr),
		.store            (store),
		.flush            (flush),
		.redirect         (redirect),
		.btb_wr           (btb_wr),
		.pred_upd         (pred_upd),
		.branch_total     (branch_total),
		.mispredict_total (mispredict_total)
	);

	function automatic logic [31:0] next_random();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return {16'd0, seed[31:16]}; // upper bits are the better ones.
	endfunction

	function automatic int credits_held();
		return rob_depth - pushed + returned;
	endfunction

	task automatic abort_run(input string line);
		$display("%s", line);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string msg);
		abort_run($sformatf("error at %0d ns: %s", $time, msg));
	endtask

	task automatic check_reg_write(input reg_write got);
		if (reg_seen >= exp_reg.size())
			abort_run("a register write retired that the test does not expect");
		else if (got !== exp_reg[reg_seen])
			report_mismatch($sformatf("register write r%0d = %h, expected r%0d = %h",
				got.dest, got.value, exp_reg[reg_seen].dest, exp_reg[reg_seen].value));
		else
			reg_seen++;
	endtask

	task automatic check_redirect(input redirect_req got);
		if (redirect_seen >= exp_redirect.size())
			abort_run("a redirect appeared that the test does not expect");
		else if (got !== exp_redirect[redirect_seen])
			report_mismatch($sformatf("redirect to %h, expected %h",
				got.new_pc, exp_redirect[redirect_seen].new_pc));
		else
			redirect_seen++;
	endtask

	task automatic check_btb_write(input btb_write got);
		if (btb_seen >= exp_btb.size())
			abort_run("a BTB write appeared that the test does not expect");
		else if (got !== exp_btb[btb_seen])
			report_mismatch($sformatf("BTB write %h, expected %h", got, exp_btb[btb_seen]));
		else
			btb_seen++;
	endtask

	task automatic check_pred_update(input pred_update got);
		if (pred_seen >= exp_pred.size())
			abort_run("a predictor update appeared that the test does not expect");
		else if (got !== exp_pred[pred_seen])
			report_mismatch($sformatf("predictor update %h, expected %h",
				got, exp_pred[pred_seen]));
		else
			pred_seen++;
	endtask

	task automatic check_store(input store_req got);
		if (store_seen >= exp_store.size())
			abort_run("a store retired that the test does not expect");
		else if (got !== exp_store[store_seen])
			report_mismatch($sformatf("store %h to %h, expected %h to %h", got.data,
				got.addr, exp_store[store_seen].data, exp_store[store_seen].addr));
		else
			store_seen++;
	endtask

	task automatic check_word(input string what, input lc3b_word got, input lc3b_word exp);
		if (got !== exp)
			report_mismatch($sformatf("%s is %h, expected %h", what, got, exp));
	endtask

	task automatic load_tests();
		int          fd;
		string       line;
		int          field [7];
		rob_entry    entry;
		reg_write    rw;
		redirect_req rd;
		btb_write    bw;
		pred_update  pu;
		store_req    st;
		fd = $fopen("dv/commit_tests.txt", "r");
		if (fd == 0)
			abort_run("cannot open the test file dv/commit_tests.txt");
		while ($fgets(line, fd) != 0)
		begin
			if ((line.len() < 2) || (line[0] == "#"))
				continue; // blank lines and column notes.
			case (line[0])
				"E":
				begin
					void'($sscanf(line, "E %h %h %h %h %h %h %h", field[0], field[1],
						field[2], field[3], field[4], field[5], field[6]));
					entry.opcode = lc3b_opcode'(field[0][3:0]);
					entry.dest = field[1][2:0];
					entry.value = field[2][15:0];
					entry.pc = field[3][15:0];
					entry.predict = field[4][0];
					entry.bht = field[5][1:0];
					entries.push_back(entry);
					wrong_path.push_back(field[6][0]);
				end
				"R":
				begin
					void'($sscanf(line, "R %h %h", field[0], field[1]));
					rw = {1'b1, field[0][2:0], field[1][15:0]};
					exp_reg.push_back(rw);
				end
				"P":
				begin
					void'($sscanf(line, "P %h", field[0]));
					rd = {1'b1, field[0][15:0]};
					exp_redirect.push_back(rd);
				end
				"B":
				begin
					void'($sscanf(line, "B %h %h %h %h", field[0], field[1], field[2],
						field[3]));
					bw = {1'b1, field[0][5:0], field[1][8:0], field[2][15:0], 1'b1,
						field[3][0]};
					exp_btb.push_back(bw);
				end
				"U":
				begin
					void'($sscanf(line, "U %h %h %h", field[0], field[1], field[2]));
					pu = {1'b1, field[0][0], field[1][1:0], field[2][15:0]};
					exp_pred.push_back(pu);
				end
				"S":
				begin
					void'($sscanf(line, "S %h %h", field[0], field[1]));
					st = {1'b1, field[0][15:0], field[1][15:0]};
					exp_store.push_back(st);
				end
				"C":
				begin
					void'($sscanf(line, "C %h %h", field[0], field[1]));
					exp_branches = field[0][15:0];
					exp_mispredicts = field[1][15:0];
				end
				default: abort_run($sformatf("unknown record in the test file: %s", line));
			endcase
		end
		$fclose(fd);
	endtask

	// one push per falling edge while credits last.
	task automatic drive_next_entry();
		push = 1'b0;
		if (flush_count != flushes_handled)
		begin
			while ((next_idx < entries.size()) && wrong_path[next_idx])
				next_idx++; // wrong path never reaches the queue now.
			flushes_handled = flush_count;
			hold_for_flush = 1'b0;
		end
		if (!hold_for_flush && (next_idx < entries.size()) && (credits_held() > 0))
		begin
			push = 1'b1;
			push_entry = entries[next_idx];
			pushed++;
			// the correct path resumes only once the flush has emptied the queue.
			if (wrong_path[next_idx] &&
				((next_idx + 1 == entries.size()) || !wrong_path[next_idx + 1]))
				hold_for_flush = 1'b1;
			next_idx++;
		end
	endtask

	// memory model, answers each store after 0 to 3 cycles.
	always @(negedge clk)
	begin
		dmem_resp = 1'b0;
		if (running)
		begin
			if (!resp_armed && store.write)
			begin
				resp_armed = 1'b1;
				resp_wait = int'(next_random() % 32'd4);
			end
			if (resp_armed)
			begin
				if (resp_wait == 0)
				begin
					dmem_resp = 1'b1;
					resp_armed = 1'b0;
				end
				else
					resp_wait--;
			end
		end
	end

	always @(posedge clk)
	begin
		cycle_count++;
		if (running)
		begin
			if (cycle_count > cycle_limit)
				abort_run($sformatf("timeout: the run did not drain within %0d cycles",
					cycle_limit));
			returned += int'(credit_return);
			if (credits_held() > rob_depth)
				abort_run("the queue returned more credits than it was given");
			if (reg_wr.valid)
				check_reg_write(reg_wr);
			if (redirect.valid)
				check_redirect(redirect);
			if (btb_wr.we)
				check_btb_write(btb_wr);
			if (pred_upd.valid)
				check_pred_update(pred_upd);
			if (store_open && (store !== store_last))
				abort_run("a store request changed before memory answered it");
			if (store.write && dmem_resp)
				check_store(store);
			store_open = store.write && !dmem_resp;
			store_last = store;
			if (flush)
				flush_count++;
		end
	end

	initial
	begin
		rst_n = 1'b0;
		push = 1'b0;
		push_entry = '0;
		next_idx = 0;
		flushes_handled = 0;
		hold_for_flush = 1'b0;
		load_tests();
		cycle_limit = 40 * entries.size() + 200;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		running = 1'b1;
		while ((next_idx < entries.size()) || (credits_held() != rob_depth))
		begin
			@(negedge clk);
			drive_next_entry();
		end
		check_word("branch total", branch_total, exp_branches);
		check_word("mispredict total", mispredict_total, exp_mispredicts);
		// each redirect comes with exactly one flush pulse.
		check_word("flush count", lc3b_word'(flush_count),
			lc3b_word'(exp_redirect.size()));
		if ((reg_seen != exp_reg.size()) || (redirect_seen != exp_redirect.size()) ||
			(btb_seen != exp_btb.size()) || (pred_seen != exp_pred.size()) ||
			(store_seen != exp_store.size()))
			abort_run("the queue drained with expected results that never appeared");
		else
		begin
			$display("SIMULATION PASSED");
			$finish;
		end
	end

endmodule : commit_tb

`default_nettype wire

/* dv/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock
#(
	parameter int half_period = 10  // ns, so one cycle is 20 ns.
)
(
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever
			#(half_period) clk = ~clk;
	end

endmodule : tb_clock

`default_nettype wire

/* src/commit_top.sv */
`timescale 1ns/1ps
`default_nettype none

module commit_top
(
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         push,
	input  lc3b_commit_pkg::rob_entry    push_entry,
	input  logic                         dmem_resp,
	output lc3b_commit_pkg::rob_count    credit_return,
	output lc3b_commit_pkg::reg_write    reg_wr,
	output lc3b_commit_pkg::store_req    store,
	output logic                         flush,
	output lc3b_commit_pkg::redirect_req redirect,
	output lc3b_commit_pkg::btb_write    btb_wr,
	output lc3b_commit_pkg::pred_update  pred_upd,
	output lc3b_commit_pkg::lc3b_word    branch_total,
	output lc3b_commit_pkg::lc3b_word    mispredict_total
);
	import lc3b_commit_pkg::*;

	logic     pop;
	logic     head_valid;
	rob_entry head;
	logic     ld_cc;
	logic     branch_taken;
	logic     resolve_en;
	logic     mispredict;
	logic     branch_retired;
	logic     mispredict_retired;

	rob_queue i_rob_queue
	(
		.clk           (clk),
		.rst_n         (rst_n),
		.push          (push),
		.push_entry    (push_entry),
		.pop           (pop),
		.flush         (flush),
		.head_valid    (head_valid),
		.head          (head),
		.credit_return (credit_return)
	);

	// the branch mask sits in the dest field.
	cc_resolve i_cc_resolve
	(
		.clk          (clk),
		.rst_n        (rst_n),
		.ld_cc        (ld_cc),
		.value        (head.value),
		.nzp_mask     (head.dest),
		.branch_taken (branch_taken)
	);

	redirect_unit i_redirect_unit
	(
		.resolve_en   (resolve_en),
		.head         (head),
		.branch_taken (branch_taken),
		.mispredict   (mispredict),
		.redirect     (redirect),
		.btb_wr       (btb_wr),
		.pred_upd     (pred_upd)
	);

	branch_stats i_branch_stats
	(
		.clk                (clk),
		.rst_n              (rst_n),
		.branch_retired     (branch_retired),
		.mispredict_retired (mispredict_retired),
		.branch_total       (branch_total),
		.mispredict_total   (mispredict_total)
	);

	commit_fsm i_commit_fsm
	(
		.clk                (clk),
		.rst_n              (rst_n),
		.head_valid         (head_valid),
		.head               (head),
		.mispredict         (mispredict),
		.dmem_resp          (dmem_resp),
		.pop                (pop),
		.flush              (flush),
		.ld_cc              (ld_cc),
		.resolve_en         (resolve_en),
		.branch_retired     (branch_retired),
		.mispredict_retired (mispredict_retired),
		.reg_wr             (reg_wr),
		.store              (store)
	);

endmodule : commit_top

`default_nettype wire

/* src/commit_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module commit_fsm
(
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      head_valid,
	input  lc3b_commit_pkg::rob_entry head,
	input  logic                      mispredict,
	input  logic                      dmem_resp,
	output logic                      pop,
	output logic                      flush,
	output logic                      ld_cc,
	output logic                      resolve_en,
	output logic                      branch_retired,
	output logic                      mispredict_retired,
	output lc3b_commit_pkg::reg_write reg_wr,
	output lc3b_commit_pkg::store_req store
);
	import lc3b_commit_pkg::*;

	commit_state state;
	commit_state next_state;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			state <= run;
		else
			state <= next_state;
	end

	always_comb
	begin
		next_state = state;
		pop = 1'b0;
		flush = 1'b0;
		ld_cc = 1'b0;
		resolve_en = 1'b0;
		branch_retired = 1'b0;
		mispredict_retired = 1'b0;
		reg_wr.valid = 1'b0;
		reg_wr.dest = head.dest;
		reg_wr.value = head.value;
		store.write = 1'b0;
		store.addr = head.value;
		store.data = head.pc;

		case (state)
			run:
			begin
				if (head_valid)
				begin
					case (head.opcode)
						op_add, op_and, op_not, op_shf, op_lea, op_ldr, op_ldb, op_rti:
						begin
							reg_wr.valid = 1'b1;
							ld_cc = 1'b1;
							pop = 1'b1;
						end
						op_br:
						begin
							resolve_en = 1'b1;
							branch_retired = 1'b1;
							pop = 1'b1;
							if (mispredict)
							begin
								flush = 1'b1;
								mispredict_retired = 1'b1;
								next_state = flush_gap;
							end
						end
						op_trap:
						begin
							reg_wr.valid = 1'b1; // value doubles as the trap target.
							resolve_en = 1'b1;
							flush = 1'b1;
							pop = 1'b1;
							next_state = flush_gap;
						end
						op_str, op_stb:
						begin
							store.write = 1'b1;
							if (dmem_resp)
								pop = 1'b1; // zero-latency response.
							else
								next_state = store_wait;
						end
						default: pop = 1'b1; // retires with no effect.
					endcase
				end
			end
			store_wait:
			begin
				store.write = 1'b1; // held until memory answers.
				if (dmem_resp)
				begin
					pop = 1'b1;
					next_state = run;
				end
			end
			flush_gap: next_state = run; // queue is empty, let fetch restart.
			default: next_state = run;
		endcase
	end

	// while a store waits, its entry stays at the head and nothing flushes it.
	a_no_flush_in_store: assert property (@(posedge clk) disable iff (!rst_n)
		(state == store_wait) |-> (!flush && head_valid &&
			((head.opcode == op_str) || (head.opcode == op_stb))));

endmodule : commit_fsm

`default_nettype wire

/* src/branch_stats.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_stats
(
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     branch_retired,
	input  logic                     mispredict_retired,
	output lc3b_commit_pkg::lc3b_word branch_total,
	output lc3b_commit_pkg::lc3b_word mispredict_total
);
	import lc3b_commit_pkg::*;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			branch_total <= '0;
			mispredict_total <= '0;
		end
		else
		begin
			if (branch_retired && (branch_total != '1))
				branch_total <= branch_total + lc3b_word'(1); // saturates at all ones.
			if (mispredict_retired && (mispredict_total != '1))
				mispredict_total <= mispredict_total + lc3b_word'(1);
		end
	end

	// a misprediction is only ever counted together with its branch.
	a_mispredict_bound: assert property (@(posedge clk) disable iff (!rst_n)
		mispredict_total <= branch_total);

endmodule : branch_stats

`default_nettype wire

/* src/redirect_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module redirect_unit
(
	input  logic                         resolve_en,
	input  lc3b_commit_pkg::rob_entry    head,
	input  logic                         branch_taken,
	output logic                         mispredict,
	output lc3b_commit_pkg::redirect_req redirect,
	output lc3b_commit_pkg::btb_write    btb_wr,
	output lc3b_commit_pkg::pred_update  pred_upd
);
	import lc3b_commit_pkg::*;

	logic     is_br;
	logic     is_trap;
	lc3b_word fall_pc;
	lc3b_word next_pc;

	assign is_br = (head.opcode == op_br);
	assign is_trap = (head.opcode == op_trap);

	assign fall_pc = head.pc + pc_step;
	assign next_pc = branch_taken ? (fall_pc + head.value) : fall_pc; // actual outcome.

	assign mispredict = resolve_en && is_br && (branch_taken != head.predict);

	// traps always leave, branches only when the guess was wrong.
	assign redirect.valid = resolve_en && (is_trap || mispredict);
	assign redirect.new_pc = is_trap ? head.value : next_pc;

	// the btb learns from every branch.
	assign btb_wr.we = resolve_en && is_br;
	assign btb_wr.index = head.pc[6:1];
	assign btb_wr.tag = head.pc[15:7];
	assign btb_wr.target = next_pc;
	assign btb_wr.valid = btb_wr.we;
	assign btb_wr.predict = branch_taken;

	assign pred_upd.valid = resolve_en && is_br;
	assign pred_upd.taken = branch_taken;
	assign pred_upd.bht = head.bht;   // history seen at predict time.
	assign pred_upd.pc = head.pc;

endmodule : redirect_unit

`default_nettype wire

/* src/cc_resolve.sv */
`timescale 1ns/1ps
`default_nettype none

module cc_resolve
(
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     ld_cc,
	input  lc3b_commit_pkg::lc3b_word value,
	input  lc3b_commit_pkg::lc3b_reg  nzp_mask,
	output logic                     branch_taken
);
	import lc3b_commit_pkg::*;

	lc3b_nzp gen_cc;
	lc3b_nzp cc;

	// sign class of the retiring value, one flag per code.
	assign gen_cc[2] = value[15];
	assign gen_cc[1] = (value == '0);
	assign gen_cc[0] = !value[15] && (value != '0);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			cc <= '0;
		else if (ld_cc)
			cc <= gen_cc;
	end

	assign branch_taken = |(nzp_mask & cc); // any requested code set.

	a_cc_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		(cc != '0) |-> $onehot(cc));

endmodule : cc_resolve

`default_nettype wire

/* src/rob_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module rob_queue
(
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      push,
	input  lc3b_commit_pkg::rob_entry push_entry,
	input  logic                      pop,
	input  logic                      flush,
	output logic                      head_valid,
	output lc3b_commit_pkg::rob_entry head,
	output lc3b_commit_pkg::rob_count credit_return
);
	import lc3b_commit_pkg::*;

	rob_entry slots [rob_depth];
	rob_addr  head_ptr;
	rob_addr  tail_ptr;
	rob_count count;

	assign head_valid = (count != '0);
	assign head = slots[head_ptr];

	// a flush frees every occupied slot, and a push in the flush cycle is dropped.
	assign credit_return = flush ? (count + rob_count'(push)) : rob_count'(pop);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			head_ptr <= '0;
			tail_ptr <= '0;
			count <= '0;
		end
		else if (flush)
		begin
			head_ptr <= '0;
			tail_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				tail_ptr <= tail_ptr + rob_addr'(1); // wraps at depth 8.
			if (pop)
				head_ptr <= head_ptr + rob_addr'(1);
			count <= count + rob_count'(push) - rob_count'(pop);
		end
	end

	always_ff @(posedge clk)
	begin
		if (push && !flush)
			slots[tail_ptr] <= push_entry;
	end

	// dispatch must respect its credits.
	a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
		push |-> (count != rob_count'(rob_depth)));

	// the commit side only retires what is present.
	a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
		pop |-> head_valid);

endmodule : rob_queue

`default_nettype wire

/* src/lc3b_commit_pkg.sv */
`default_nettype none

package lc3b_commit_pkg;

	typedef logic [15:0] lc3b_word;  // data word and pc.
	typedef logic [2:0]  lc3b_reg;   // register index, or nzp mask on a branch.
	typedef logic [2:0]  lc3b_nzp;
	typedef logic [1:0]  lc3b_bht;
	typedef logic [5:0]  btb_index;  // pc[6:1].
	typedef logic [8:0]  btb_tag;    // pc[15:7].
	typedef logic [2:0]  rob_addr;
	typedef logic [3:0]  rob_count;

	typedef enum logic [3:0]
	{
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	typedef enum logic [1:0]
	{
		run,
		store_wait,
		flush_gap
	} commit_state;

	localparam int rob_depth = 8;
	localparam lc3b_word pc_step = 16'd2;

	typedef struct packed
	{
		lc3b_opcode opcode;
		lc3b_reg    dest;     // nzp mask for branches.
		lc3b_word   value;    // result, branch offset, trap vector or store address.
		lc3b_word   pc;       // store data rides here for str/stb.
		logic       predict;
		lc3b_bht    bht;
	} rob_entry;

	typedef struct packed
	{
		logic     valid;
		lc3b_reg  dest;
		lc3b_word value;
	} reg_write;

	typedef struct packed
	{
		logic     valid;
		lc3b_word new_pc;
	} redirect_req;

	typedef struct packed
	{
		logic     we;
		btb_index index;
		btb_tag   tag;
		lc3b_word target;
		logic     valid;
		logic     predict;
	} btb_write;

	typedef struct packed
	{
		logic     valid;
		logic     taken;
		lc3b_bht  bht;
		lc3b_word pc;
	} pred_update;

	typedef struct packed
	{
		logic     write;
		lc3b_word addr;   // from entry value.
		lc3b_word data;   // from entry pc.
	} store_req;

endpackage : lc3b_commit_pkg

`default_nettype wire
